/* flist.f */
logic/video_pkg.sv
logic/video_timing_if.sv
logic/video_timer.sv
logic/tile_layer.sv
logic/sprite_layer.sv
logic/color_mixer.sv
logic/arcade_video.sv
testbench/arcade_video_tb.sv

/* logic/arcade_video.sv */
/*
   Video section top level. Connects the raster timer, the tile and sprite
   layers and the colour mixer. The raster sizes are set here.
*/
`default_nettype none

module arcade_video #(
    parameter int unsigned H_ACTIVE = 256,
    parameter int unsigned H_TOTAL  = 384,
    parameter int unsigned V_ACTIVE = 224,
    parameter int unsigned V_TOTAL  = 264
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,

    // CPU access to tile and object RAM
    input  logic [video_pkg::CPU_AW-1:0] cpu_addr,
    input  logic [7:0]                   cpu_dout,
    input  logic                         cpu_rnw,
    input  logic                         vram_cs,
    output logic [7:0]                   vram_dout,
    input  logic                         objram_cs,
    output logic [7:0]                   obj_dout,

    // Palette PROM loading
    input  logic [video_pkg::PAL_AW-1:0] prog_addr,
    input  logic [7:0]                   prog_data,
    input  logic                         prog_en,

    // Graphics ROM
    output logic [video_pkg::ROM_AW-1:0] rom_addr,
    input  logic [video_pkg::ROM_DW-1:0] rom_data,

    output logic                         hs,
    output logic                         vs,
    output logic                         lhbl,
    output logic                         lvbl,
    output logic [3:0]                   red,
    output logic [3:0]                   green,
    output logic [3:0]                   blue
);
    import video_pkg::*;

    pxl_t tile_pxl;
    pxl_t obj_pxl;
    logic tile_prio;

    video_timing_if vt ();

    video_timer #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) u_timer (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .tm       (vt.timer),
        .hs       (hs),
        .vs       (vs)
    );

    tile_layer #(
        .H_ACTIVE (H_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) u_tile (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .tm        (vt.layer),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .cpu_rnw   (cpu_rnw),
        .vram_cs   (vram_cs),
        .vram_dout (vram_dout),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .pxl       (tile_pxl),
        .prio      (tile_prio)
    );

    sprite_layer u_sprite (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .tm        (vt.layer),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .cpu_rnw   (cpu_rnw),
        .objram_cs (objram_cs),
        .obj_dout  (obj_dout),
        .pxl       (obj_pxl)
    );

    color_mixer u_mixer (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .tm        (vt.layer),
        .tile_pxl  (tile_pxl),
        .tile_prio (tile_prio),
        .obj_pxl   (obj_pxl),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_en   (prog_en),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .lhbl      (lhbl),
        .lvbl      (lvbl)
    );

endmodule

`default_nettype wire

/* logic/color_mixer.sv */
/*
   Colour mixer: picks tile or sprite, looks the pixel up in the palette
   PROM and registers RGB with blanking aligned to the layer pixels.
*/
`default_nettype none

module color_mixer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,
    video_timing_if.layer                tm,
    input  video_pkg::pxl_t              tile_pxl,
    input  logic                         tile_prio,
    input  video_pkg::pxl_t              obj_pxl,
    input  logic [video_pkg::PAL_AW-1:0] prog_addr,
    input  logic [7:0]                   prog_data,
    input  logic                         prog_en,
    output logic [3:0]                   red,
    output logic [3:0]                   green,
    output logic [3:0]                   blue,
    output logic                         lhbl,
    output logic                         lvbl
);
    import video_pkg::*;

    logic [7:0]             pal [2**PAL_AW];
    logic [LAYER_DELAY-1:0] hbl_dly;
    logic [LAYER_DELAY-1:0] vbl_dly;
    logic                   obj_wins;
    logic [PAL_AW-1:0]      pal_idx;
    logic [7:0]             entry;
    logic                   visible;

    always_ff @(posedge clk) begin
        if (prog_en) begin
            pal[prog_addr] <= prog_data;
        end
    end

    // A tile with priority and a solid pixel hides the sprite
    always_comb begin
        obj_wins = (obj_pxl != '0) && !(tile_prio && (tile_pxl != '0));
        pal_idx  = obj_wins ? {1'b1, obj_pxl} : {1'b0, tile_pxl};
        entry    = pal[pal_idx];
        visible  = hbl_dly[LAYER_DELAY-1] && vbl_dly[LAYER_DELAY-1];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hbl_dly <= '0;
            vbl_dly <= '0;
            lhbl    <= 1'b0;
            lvbl    <= 1'b0;
            red     <= 4'd0;
            green   <= 4'd0;
            blue    <= 4'd0;
        end else if (pxl_cen) begin
            hbl_dly <= {hbl_dly[LAYER_DELAY-2:0], tm.lhbl};
            vbl_dly <= {vbl_dly[LAYER_DELAY-2:0], tm.lvbl};
            lhbl    <= hbl_dly[LAYER_DELAY-1];
            lvbl    <= vbl_dly[LAYER_DELAY-1];
            // 3-3-2 entry widened to 4 bits per gun
            red     <= visible ? {entry[2:0], entry[2]} : 4'd0;
            green   <= visible ? {entry[5:3], entry[5]} : 4'd0;
            blue    <= visible ? {entry[7:6], entry[7:6]} : 4'd0;
        end
    end

endmodule

`default_nettype wire

/* logic/sprite_layer.sv */
/*
   Sprite layer: four solid 8x8 objects held in 16 bytes of CPU RAM.
   Each object uses y, x, colour and enable bytes, and the lowest-numbered
   hit wins. The result is registered over LAYER_DELAY pixel steps.
*/
`default_nettype none

module sprite_layer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,
    video_timing_if.layer                tm,
    input  logic [video_pkg::CPU_AW-1:0] cpu_addr,
    input  logic [7:0]                   cpu_dout,
    input  logic                         cpu_rnw,
    input  logic                         objram_cs,
    output logic [7:0]                   obj_dout,
    output video_pkg::pxl_t              pxl
);
    import video_pkg::*;

    localparam int OBJS = 4;

    // Byte offsets inside an object
    localparam int OFS_Y   = 0;
    localparam int OFS_X   = 1;
    localparam int OFS_COL = 2;
    localparam int OFS_EN  = 3;

    logic [7:0] obj_ram [4*OBJS];
    logic [7:0] dx      [OBJS];
    logic [7:0] dy      [OBJS];
    logic [OBJS-1:0] hit;
    pxl_t       hit_pxl;
    pxl_t       pxl_pipe [LAYER_DELAY];

    always_ff @(posedge clk) begin
        if (objram_cs && !cpu_rnw) begin
            obj_ram[cpu_addr[3:0]] <= cpu_dout;
        end
        if (objram_cs && cpu_rnw) begin
            obj_dout <= obj_ram[cpu_addr[3:0]];
        end
    end

    // All objects tested in parallel
    always_comb begin
        for (int i = 0; i < OBJS; i++) begin
            // 8-bit differences, so an object near 255 wraps past 0
            dx[i]  = tm.hdump[7:0] - obj_ram[4*i + OFS_X];
            dy[i]  = tm.vdump[7:0] - obj_ram[4*i + OFS_Y];
            hit[i] = obj_ram[4*i + OFS_EN][0] && (dx[i] < 8'd8) && (dy[i] < 8'd8);
        end
    end

    // Walk down so object 0 has the last word
    always_comb begin
        hit_pxl = '0;
        for (int i = OBJS - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_pxl = obj_ram[4*i + OFS_COL][PXL_W-1:0];
            end
        end
    end

    // Same latency as the tile layer
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LAYER_DELAY; i++) begin
                pxl_pipe[i] <= '0;
            end
        end else if (pxl_cen) begin
            pxl_pipe[0] <= hit_pxl;
            for (int i = 1; i < LAYER_DELAY; i++) begin
                pxl_pipe[i] <= pxl_pipe[i-1];
            end
        end
    end

    assign pxl = pxl_pipe[LAYER_DELAY-1];

endmodule

`default_nettype wire

/* logic/tile_layer.sv */
/*
   Tile layer: code and attribute RAM shared with the CPU, an eight-phase
   pattern fetch from the graphics ROM and a 4-bit pixel shifter.
   Output pixels lag the beam position by LAYER_DELAY pixel steps.
*/
`default_nettype none

module tile_layer #(
    parameter int unsigned H_ACTIVE = 256,
    parameter int unsigned V_TOTAL  = 264
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,
    video_timing_if.layer                tm,
    input  logic [video_pkg::CPU_AW-1:0] cpu_addr,
    input  logic [7:0]                   cpu_dout,
    input  logic                         cpu_rnw,
    input  logic                         vram_cs,
    output logic [7:0]                   vram_dout,
    output logic [video_pkg::ROM_AW-1:0] rom_addr,
    input  logic [video_pkg::ROM_DW-1:0] rom_data,
    output video_pkg::pxl_t              pxl,
    output logic                         prio
);
    import video_pkg::*;

    localparam int unsigned COLS = H_ACTIVE / 8;

    logic [7:0]        code_ram [1024];
    logic [7:0]        attr_ram [1024];
    logic [2:0]        phase;
    logic [6:0]        next_col;
    logic              wrap_col;
    logic [8:0]        next_line;
    logic [8:0]        fetch_line;
    logic [4:0]        fetch_col;
    logic [9:0]        fetch_addr;
    logic [7:0]        code_q;
    logic [7:0]        attr_q;
    logic [2:0]        row_q;
    logic [ROM_DW-1:0] row_buf;
    logic [ROM_DW-1:0] shifter;
    logic              shift_prio;
    pxl_t              pxl_pipe  [LAYER_DELAY];
    logic              prio_pipe [LAYER_DELAY];

    assign phase = tm.hdump[2:0];

    // Past the last visible column the fetch goes to column 0 of the next line
    always_comb begin
        next_col   = {1'b0, tm.hdump[8:3]} + 7'd1;
        wrap_col   = (next_col >= 7'(COLS));
        next_line  = (tm.vdump == 9'(V_TOTAL - 1)) ? 9'd0 : tm.vdump + 9'd1;
        fetch_line = wrap_col ? next_line : tm.vdump;
        fetch_col  = wrap_col ? 5'd0 : next_col[4:0];
        fetch_addr = {fetch_line[7:3], fetch_col};
    end

    // CPU port, bit 10 picks attribute or code
    always_ff @(posedge clk) begin
        if (vram_cs && !cpu_rnw && cpu_addr[10]) begin
            attr_ram[cpu_addr[9:0]] <= cpu_dout;
        end
        if (vram_cs && !cpu_rnw && !cpu_addr[10]) begin
            code_ram[cpu_addr[9:0]] <= cpu_dout;
        end
        if (vram_cs && cpu_rnw) begin
            vram_dout <= cpu_addr[10] ? attr_ram[cpu_addr[9:0]] : code_ram[cpu_addr[9:0]];
        end
    end

    // Fetch port: RAM read at phase 0, ROM data taken at phase 2
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (phase == 3'd0) begin
                code_q <= code_ram[fetch_addr];
                attr_q <= attr_ram[fetch_addr];
                row_q  <= fetch_line[2:0];
            end
            if (phase == 3'd2) begin
                row_buf <= rom_data;
            end
        end
    end

    // Held through phase 1 and after, the ROM answers a clock later
    assign rom_addr = {code_q, row_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            shifter    <= '0;
            shift_prio <= 1'b0;
            for (int i = 0; i < LAYER_DELAY; i++) begin
                pxl_pipe[i]  <= '0;
                prio_pipe[i] <= 1'b0;
            end
        end else if (pxl_cen) begin
            if (phase == 3'd7) begin
                shifter    <= row_buf;
                shift_prio <= attr_q[4];
            end else begin
                shifter <= shifter >> PXL_W;
            end
            // Nibble 0 is the pixel under the beam
            pxl_pipe[0]  <= shifter[PXL_W-1:0];
            prio_pipe[0] <= shift_prio;
            for (int i = 1; i < LAYER_DELAY; i++) begin
                pxl_pipe[i]  <= pxl_pipe[i-1];
                prio_pipe[i] <= prio_pipe[i-1];
            end
        end
    end

    assign pxl  = pxl_pipe[LAYER_DELAY-1];
    assign prio = prio_pipe[LAYER_DELAY-1];

endmodule

`default_nettype wire

/* logic/video_pkg.sv */
/*
   Shared widths, pixel type and pipeline depth of the arcade video section.
   Modules import it inside their body and use scoped names in their ports.
*/
`default_nettype none

package video_pkg;

    // Layer pixel, value 0 is transparent
    localparam int PXL_W = 4;
    typedef logic [PXL_W-1:0] pxl_t;

    // Palette of 32 entries, 8 bits each
    localparam int PAL_AW = 5;

    // CPU address bus into tile and object RAM
    localparam int CPU_AW = 11;

    // Graphics ROM address: tile code, then tile row
    localparam int ROM_AW = 11;

    // One tile row, pixel k sits in nibble k
    localparam int ROM_DW = 32;

    // Pixel steps from timer position to a valid layer pixel
    localparam int LAYER_DELAY = 2;

endpackage

`default_nettype wire

/* logic/video_timer.sv */
/*
   Raster timer: horizontal and vertical counters, syncs and blanking.
   Counts advance on pxl_cen; the raster sizes come from the top level.
*/
`default_nettype none

module video_timer #(
    parameter int unsigned H_ACTIVE = 256,
    parameter int unsigned H_TOTAL  = 384,
    parameter int unsigned V_ACTIVE = 224,
    parameter int unsigned V_TOTAL  = 264
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          pxl_cen,
    video_timing_if.timer tm,
    output logic          hs,
    output logic          vs
);

    logic [8:0] hdump;
    logic [8:0] vdump;
    logic [8:0] hnext;
    logic [8:0] vnext;
    logic       h_wrap;

    always_comb begin
        h_wrap = (hdump == 9'(H_TOTAL - 1));
        hnext  = h_wrap ? 9'd0 : hdump + 9'd1;
        vnext  = vdump;
        // Next line only when the line ends
        if (h_wrap) begin
            vnext = (vdump == 9'(V_TOTAL - 1)) ? 9'd0 : vdump + 9'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hdump <= 9'd0;
            vdump <= 9'd0;
            hs    <= 1'b0;
            vs    <= 1'b0;
        end else if (pxl_cen) begin
            hdump <= hnext;
            vdump <= vnext;
            // Syncs follow the counters, computed from the next position
            hs    <= (hnext >= 9'(H_ACTIVE + 4)) && (hnext <= 9'(H_ACTIVE + 11));
            vs    <= (vnext >= 9'(V_ACTIVE + 2)) && (vnext <= 9'(V_ACTIVE + 3));
        end
    end

    assign tm.hdump = hdump;
    assign tm.vdump = vdump;

    // Blanking is high in the visible area
    assign tm.lhbl  = (hdump < 9'(H_ACTIVE));
    assign tm.lvbl  = (vdump < 9'(V_ACTIVE));

endmodule

`default_nettype wire

/* logic/video_timing_if.sv */
/*
   Beam position and blanking, driven by the raster timer and read by the
   tile layer, the sprite layer and the colour mixer.
*/
`default_nettype none

interface video_timing_if;

    logic [8:0] hdump;
    logic [8:0] vdump;
    logic       lhbl;
    logic       lvbl;

    // Raster timer side
    modport timer (output hdump, output vdump, output lhbl, output lvbl);

    // Layers and mixer only look at the beam
    modport layer (input hdump, input vdump, input lhbl, input lvbl);

endinterface

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the arcade video testbench with Verilator, runs it and
# decides pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -f flist.f --top-module arcade_video_tb \
    -o arcade_video_sim || { echo "Build failed"; exit 1; }

./obj_dir/arcade_video_sim > "$LOG" 2>&1 || echo "Simulator returned an error status"
cat "$LOG"

grep -q "ERRORS FOUND" "$LOG" && { echo "Simulation failed"; exit 1; }
grep -q "NO ERRORS" "$LOG" || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"

/* testbench/arcade_video_tb.sv */
/*
   Testbench for the arcade video section on a small raster. Loads a random
   palette, checks RAM readback and raster timing, then applies a scenario
   table of tiles and sprites and compares probed pixels with a reference.
*/
`default_nettype none

module arcade_video_tb;
    import video_pkg::*;

    localparam int H_ACTIVE    = 64;
    localparam int H_TOTAL     = 80;
    localparam int V_ACTIVE    = 32;
    localparam int V_TOTAL     = 40;
    localparam int FRAME_STEPS = H_TOTAL * V_TOTAL;
    localparam int SEL_LHBL    = 0;
    localparam int SEL_LVBL    = 1;
    localparam int SEL_HS      = 2;
    localparam int SEL_VS      = 3;
    localparam int N_ROWS      = 16;

    typedef struct packed {
        logic [7:0] code;
        logic       prio;
        logic [1:0] obj;
        logic [7:0] x;
        logic [7:0] y;
        logic [3:0] colour;
        logic       en;
        logic [5:0] col;
        logic [4:0] line;
        logic       sprite_wins;
    } scen_t;

    // code, prio, object, x, y, colour, enable, probe column, probe line, sprite wins
    scen_t scen [N_ROWS] = '{
        '{8'h12, 1'b0, 2'd0, 8'd0,   8'd0,  4'd0,  1'b0, 6'd5,  5'd3,  1'b0},
        '{8'h12, 1'b0, 2'd0, 8'd0,   8'd0,  4'd0,  1'b0, 6'd63, 5'd31, 1'b0},
        '{8'h3c, 1'b0, 2'd0, 8'd0,   8'd0,  4'd0,  1'b0, 6'd17, 5'd12, 1'b0},
        '{8'h05, 1'b0, 2'd0, 8'd20,  8'd10, 4'd5,  1'b1, 6'd22, 5'd12, 1'b1},
        '{8'h05, 1'b0, 2'd0, 8'd20,  8'd10, 4'd5,  1'b1, 6'd27, 5'd17, 1'b1},
        '{8'h05, 1'b0, 2'd0, 8'd20,  8'd10, 4'd5,  1'b1, 6'd28, 5'd12, 1'b0},
        '{8'h05, 1'b0, 2'd0, 8'd20,  8'd10, 4'd0,  1'b1, 6'd22, 5'd12, 1'b0},
        '{8'h05, 1'b0, 2'd0, 8'd20,  8'd10, 4'd5,  1'b1, 6'd26, 5'd16, 1'b1},
        '{8'h05, 1'b0, 2'd1, 8'd24,  8'd14, 4'd9,  1'b1, 6'd26, 5'd16, 1'b1},
        '{8'h05, 1'b0, 2'd1, 8'd24,  8'd14, 4'd9,  1'b1, 6'd30, 5'd20, 1'b1},
        '{8'h07, 1'b1, 2'd0, 8'd0,   8'd0,  4'd3,  1'b1, 6'd2,  5'd1,  1'b0},
        '{8'h00, 1'b1, 2'd0, 8'd0,   8'd0,  4'd3,  1'b1, 6'd0,  5'd0,  1'b1},
        '{8'h0e, 1'b1, 2'd0, 8'd0,   8'd0,  4'd3,  1'b1, 6'd1,  5'd1,  1'b1},
        '{8'h0e, 1'b0, 2'd0, 8'd250, 8'd0,  4'd7,  1'b1, 6'd1,  5'd3,  1'b1},
        '{8'h0e, 1'b0, 2'd1, 8'd24,  8'd14, 4'd9,  1'b0, 6'd30, 5'd20, 1'b0},
        '{8'h21, 1'b0, 2'd0, 8'd56,  8'd24, 4'd12, 1'b1, 6'd63, 5'd31, 1'b1}
    };

    string sig_names [4] = '{"lhbl", "lvbl", "hs", "vs"};

    logic              clk = 1'b0;
    logic              rst;
    logic              pxl_cen;
    logic [CPU_AW-1:0] cpu_addr;
    logic [7:0]        cpu_dout;
    logic              cpu_rnw;
    logic              vram_cs;
    logic [7:0]        vram_dout;
    logic              objram_cs;
    logic [7:0]        obj_dout;
    logic [PAL_AW-1:0] prog_addr;
    logic [7:0]        prog_data;
    logic              prog_en;
    logic [ROM_AW-1:0] rom_addr;
    logic [ROM_DW-1:0] rom_data;
    logic              hs;
    logic              vs;
    logic              lhbl;
    logic              lvbl;
    logic [3:0]        red;
    logic [3:0]        green;
    logic [3:0]        blue;

    // Mirrors of what the CPU and the PROM loader wrote
    logic [7:0]        vram_mirror [2048];
    logic [7:0]        obj_mirror  [16];
    logic [7:0]        pal_mirror  [32];
    logic [CPU_AW-1:0] rb_addr     [16];
    int                seed = 44870;
    int                n;
    int                n2;
    int                hs_rises;
    int                steps;
    logic              prev_hs;
    logic              prev_vs;
    logic              vs_rise;
    logic [11:0]       got;
    logic [11:0]       expected;
    logic [4:0]        idx;

    arcade_video #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) arcade_video_i (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .cpu_rnw   (cpu_rnw),
        .vram_cs   (vram_cs),
        .vram_dout (vram_dout),
        .objram_cs (objram_cs),
        .obj_dout  (obj_dout),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_en   (prog_en),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .hs        (hs),
        .vs        (vs),
        .lhbl      (lhbl),
        .lvbl      (lvbl),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

    always #5 clk = ~clk;

    // Pixel step on every second clock
    always @(posedge clk) begin
        pxl_cen <= ~pxl_cen;
    end

    // Graphics ROM model with nibble k of a row equal to code + row + k
    function automatic logic [ROM_DW-1:0] rom_row(input logic [ROM_AW-1:0] addr);
        logic [ROM_DW-1:0] row;
        row = '0;
        for (int k = 0; k < 8; k++) begin
            row[4*k +: 4] = 4'((int'(addr[10:3]) + int'(addr[2:0]) + k) % 16);
        end
        return row;
    endfunction

    always @(posedge clk) begin
        rom_data <= rom_row(rom_addr);
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    // RGB must be black outside the visible area
    always @(negedge clk) begin
        if (!rst && pxl_cen && !(lhbl && lvbl)) begin
            assert ({red, green, blue} == 12'd0)
            else stop_run($sformatf("MISMATCH at time %0t: RGB %h during blanking",
                                    $time, {red, green, blue}));
        end
    end

    function automatic logic sig_level(input int sel);
        case (sel)
            SEL_LHBL: return lhbl;
            SEL_LVBL: return lvbl;
            SEL_HS:   return hs;
            default:  return vs;
        endcase
    endfunction

    // Outputs are sampled once per pixel step between update edges
    task automatic next_step;
        int guard;
        guard = 0;
        @(negedge clk);
        while (!pxl_cen) begin
            guard++;
            assert (guard < 4) else stop_run("Pixel clock enable stopped toggling");
            @(negedge clk);
        end
    endtask

    task automatic count_until(input int sel, input logic level, output int cnt);
        cnt = 0;
        do begin
            next_step;
            cnt++;
            assert (cnt <= 2 * FRAME_STEPS)
            else stop_run($sformatf("Timed out waiting for %s to become %0d",
                                    sig_names[sel], level));
        end while (sig_level(sel) != level);
    endtask

    // Ends on the first visible step of a frame that started after the call
    task automatic sync_frame;
        int cnt;
        count_until(SEL_LVBL, 1'b1, cnt);
        count_until(SEL_LVBL, 1'b0, cnt);
        count_until(SEL_LVBL, 1'b1, cnt);
    endtask

    task automatic cpu_write(input logic obj, input logic [CPU_AW-1:0] addr,
                             input logic [7:0] data);
        @(posedge clk);
        cpu_addr  <= addr;
        cpu_dout  <= data;
        cpu_rnw   <= 1'b0;
        vram_cs   <= !obj;
        objram_cs <= obj;
        @(posedge clk);
        vram_cs   <= 1'b0;
        objram_cs <= 1'b0;
        cpu_rnw   <= 1'b1;
        if (obj) begin
            obj_mirror[addr[3:0]] = data;
        end else begin
            vram_mirror[addr] = data;
        end
    endtask

    task automatic read_check(input logic obj, input logic [CPU_AW-1:0] addr);
        logic [7:0] want;
        logic [7:0] seen;
        int         clocks;
        want = obj ? obj_mirror[addr[3:0]] : vram_mirror[addr];
        @(posedge clk);
        cpu_addr  <= addr;
        cpu_rnw   <= 1'b1;
        vram_cs   <= !obj;
        objram_cs <= obj;
        clocks = 0;
        do begin
            @(posedge clk);
            vram_cs   <= 1'b0;
            objram_cs <= 1'b0;
            clocks++;
            @(negedge clk);
            seen = obj ? obj_dout : vram_dout;
        end while (seen != want && clocks < 4);
        assert (seen == want && clocks == 1)
        else stop_run($sformatf("MISMATCH at time %0t: %s[%0d] = %h after %0d clk, want %h",
                                $time, obj ? "obj" : "vram", addr, seen, clocks, want));
    endtask

    task automatic load_palette(input logic [PAL_AW-1:0] addr, input logic [7:0] data);
        @(posedge clk);
        prog_addr <= addr;
        prog_data <= data;
        prog_en   <= 1'b1;
        @(posedge clk);
        prog_en   <= 1'b0;
        pal_mirror[addr] = data;
    endtask

    // Probed tile holds the row's code and priority, the others differ from it
    task automatic place_scene(input scen_t s);
        logic [7:0] attr;
        logic [7:0] code;
        logic       prio;
        int         probe_tr;
        int         probe_tc;
        probe_tr = int'(s.line) / 8;
        probe_tc = int'(s.col) / 8;
        for (int tr = 0; tr < V_ACTIVE / 8; tr++) begin
            for (int tc = 0; tc < H_ACTIVE / 8; tc++) begin
                // Codes step by one per tile so a wrong map address shows up
                code = s.code + 8'((tr - probe_tr) * 8 + (tc - probe_tc));
                prio = (tr == probe_tr && tc == probe_tc) ? s.prio : !s.prio;
                attr = (8'($random(seed)) & 8'hef) | {3'd0, prio, 4'd0};
                cpu_write(1'b0, 11'(tr * 32 + tc), code);
                cpu_write(1'b0, 11'(1024 + tr * 32 + tc), attr);
            end
        end
        cpu_write(1'b1, {7'd0, s.obj, 2'd0}, s.y);
        cpu_write(1'b1, {7'd0, s.obj, 2'd1}, s.x);
        cpu_write(1'b1, {7'd0, s.obj, 2'd2}, {4'($random(seed)), s.colour});
        cpu_write(1'b1, {7'd0, s.obj, 2'd3}, {7'($random(seed)), s.en});
    endtask

    // Position counted by visible lines and visible steps at the outputs
    task automatic probe_pixel(input int col, input int line, output logic [11:0] rgb);
        int cnt;
        sync_frame;
        for (int m = 0; m < line; m++) begin
            count_until(SEL_LHBL, 1'b0, cnt);
            count_until(SEL_LHBL, 1'b1, cnt);
        end
        repeat (col) next_step;
        assert (lhbl && lvbl) else stop_run("Probe position fell outside the visible area");
        rgb = {red, green, blue};
    endtask

    // Palette index of the winning layer at a visible pixel
    function automatic logic [4:0] ref_index(input int col, input int line);
        logic [7:0] code;
        logic [7:0] attr;
        logic [3:0] tile_nib;
        logic [3:0] obj_nib;
        logic       obj_hit;
        logic [7:0] dx;
        logic [7:0] dy;
        code     = vram_mirror[(line / 8) * 32 + col / 8];
        attr     = vram_mirror[1024 + (line / 8) * 32 + col / 8];
        tile_nib = 4'((int'(code) + line % 8 + col % 8) % 16);
        obj_hit  = 1'b0;
        obj_nib  = 4'd0;
        for (int i = 0; i < 4; i++) begin
            dx = 8'(col - int'(obj_mirror[4 * i + 1]));
            dy = 8'(line - int'(obj_mirror[4 * i]));
            if (!obj_hit && obj_mirror[4 * i + 3][0] && dx < 8'd8 && dy < 8'd8) begin
                obj_hit = 1'b1;
                obj_nib = obj_mirror[4 * i + 2][3:0];
            end
        end
        if (attr[4] && tile_nib != 4'd0) begin
            return {1'b0, tile_nib};
        end else if (obj_nib != 4'd0) begin
            return {1'b1, obj_nib};
        end else begin
            return {1'b0, tile_nib};
        end
    endfunction

    function automatic logic [11:0] expand(input logic [7:0] e);
        return {e[2:0], e[2], e[5:3], e[5], e[7:6], e[7:6]};
    endfunction

    initial begin
        rst       = 1'b1;
        pxl_cen   = 1'b0;
        cpu_addr  = '0;
        cpu_dout  = 8'd0;
        cpu_rnw   = 1'b1;
        vram_cs   = 1'b0;
        objram_cs = 1'b0;
        prog_addr = '0;
        prog_data = 8'd0;
        prog_en   = 1'b0;
        rom_data  = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 32; i++) begin
            load_palette(5'(i), 8'($random(seed)));
        end

        // RAM readback with objects cleared afterwards
        for (int i = 0; i < 16; i++) begin
            rb_addr[i] = 11'($random(seed));
            cpu_write(1'b0, rb_addr[i], 8'($random(seed)));
        end
        for (int i = 0; i < 16; i++) begin
            read_check(1'b0, rb_addr[i]);
        end
        for (int i = 0; i < 16; i++) begin
            cpu_write(1'b1, 11'(i), 8'($random(seed)));
        end
        for (int i = 0; i < 16; i++) begin
            read_check(1'b1, 11'(i));
        end
        for (int i = 0; i < 16; i++) begin
            cpu_write(1'b1, 11'(i), 8'd0);
        end

        // Line period from hs
        count_until(SEL_HS, 1'b0, n);
        count_until(SEL_HS, 1'b1, n);
        count_until(SEL_HS, 1'b0, n);
        count_until(SEL_HS, 1'b1, n2);
        assert (n + n2 == H_TOTAL)
        else stop_run($sformatf("MISMATCH at time %0t: %0d steps per line", $time, n + n2));

        // Lines per frame from vs
        count_until(SEL_VS, 1'b0, n);
        count_until(SEL_VS, 1'b1, n);
        prev_hs  = hs;
        prev_vs  = 1'b1;
        hs_rises = 0;
        steps    = 0;
        do begin
            next_step;
            steps++;
            if (hs && !prev_hs) begin
                hs_rises++;
            end
            vs_rise = vs && !prev_vs;
            prev_hs = hs;
            prev_vs = vs;
            assert (steps <= 2 * FRAME_STEPS) else stop_run("Timed out counting hs pulses");
        end while (!vs_rise);
        assert (hs_rises == V_TOTAL)
        else stop_run($sformatf("MISMATCH at time %0t: %0d hs pulses per frame", $time, hs_rises));

        sync_frame;
        for (int m = 0; m < V_ACTIVE; m++) begin
            count_until(SEL_LHBL, 1'b0, n);
            assert (n == H_ACTIVE)
            else stop_run($sformatf("MISMATCH at time %0t: line %0d has %0d visible steps",
                                    $time, m, n));
            count_until(SEL_LHBL, 1'b1, n);
        end

        for (int r = 0; r < N_ROWS; r++) begin
            place_scene(scen[r]);
            probe_pixel(int'(scen[r].col), int'(scen[r].line), got);
            idx = ref_index(int'(scen[r].col), int'(scen[r].line));
            assert (idx[4] == scen[r].sprite_wins)
            else stop_run($sformatf("Reference model picks the other layer in scenario row %0d", r));
            expected = expand(pal_mirror[idx]);
            assert (got == expected)
            else stop_run($sformatf("MISMATCH at time %0t: row %0d at (%0d,%0d) RGB %h, want %h",
                                    $time, r, scen[r].col, scen[r].line, got, expected));
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
